//--- compile.f
verilog/mau_pkg.sv
verilog/mau_hdr_if.sv
verilog/mau_tag_if.sv
verilog/mau_fifo.sv
verilog/beat_counter.sv
verilog/mau_arbiter.sv
verilog/wb_issue_fsm.sv
verilog/line_assembler.sv
verilog/l1_mau.sv
test/tb_clkgen.sv
test/tb_wb_slave.sv
test/tb_l1_mau.sv

//--- test/tb_clkgen.sv
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clkgen #(
	parameter real PERIOD_NS    = 4.0,
	parameter int  RESET_CYCLES = 16
) (
	output logic wb_clk_o,
	output logic wb_rst_o
);

	initial begin
		wb_clk_o = 1'b0;
		forever #(PERIOD_NS / 2.0) wb_clk_o = ~wb_clk_o;
	end

	// Reset released on a rising edge
	initial begin
		wb_rst_o = 1'b1;
		repeat (RESET_CYCLES) @(posedge wb_clk_o);
		wb_rst_o <= 1'b0;
	end

endmodule

//--- test/tb_l1_mau.sv
// L1 memory access unit testbench
`timescale 1ns/1ps

module tb_l1_mau
	import mau_pkg::*;
();

	localparam int          REQ_PER_PORT   = 200;
	localparam int          RESET_CYCLES   = 16;
	localparam int          TIMEOUT_CYCLES = 2 * REQ_PER_PORT * 24 + RESET_CYCLES;
	localparam logic [31:0] BASE           = 32'h0000_4000;

	logic  wb_clk;
	logic  wb_rst;
	logic  l1i_req_val;
	addr_t l1i_req_addr;
	logic  l1i_req_ack;
	line_t l1i_ack_data;
	logic  l1d_req_val;
	logic  l1d_req_nc;
	logic  l1d_req_we;
	addr_t l1d_req_addr;
	data_t l1d_req_wdata;
	be_t   l1d_req_be;
	logic  l1d_req_ack;
	line_t l1d_ack_data;
	logic  l1d_ack_nc;
	logic  l1d_ack_we;
	data_t wb_dat_s2m;
	data_t wb_dat_m2s;
	logic  wb_ack;
	addr_t wb_adr;
	logic  wb_cyc;
	logic  wb_stall;
	be_t   wb_sel;
	logic  wb_stb;
	logic  wb_we;

	// Reference memory and request bookkeeping
	data_t  model_mem [64];
	integer seed;
	int     errors;
	int     checks;
	int     cyc_cnt;
	logic   started;
	logic   timed_out;
	logic   i_pend;
	addr_t  i_addr;
	int     i_sent;
	int     i_done;
	logic   d_pend;
	int     d_sent;
	int     d_done;

	tb_clkgen #(.PERIOD_NS(4.0), .RESET_CYCLES(RESET_CYCLES)) i_clkgen (
		.wb_clk_o (wb_clk),
		.wb_rst_o (wb_rst)
	);

	l1_mau i_dut (
		.wb_clk_i        (wb_clk),
		.wb_rst_i        (wb_rst),
		.l1i_req_val_i   (l1i_req_val),
		.l1i_req_addr_i  (l1i_req_addr),
		.l1i_req_ack_o   (l1i_req_ack),
		.l1i_ack_data_o  (l1i_ack_data),
		.l1d_req_val_i   (l1d_req_val),
		.l1d_req_nc_i    (l1d_req_nc),
		.l1d_req_we_i    (l1d_req_we),
		.l1d_req_addr_i  (l1d_req_addr),
		.l1d_req_wdata_i (l1d_req_wdata),
		.l1d_req_be_i    (l1d_req_be),
		.l1d_req_ack_o   (l1d_req_ack),
		.l1d_ack_data_o  (l1d_ack_data),
		.l1d_ack_nc_o    (l1d_ack_nc),
		.l1d_ack_we_o    (l1d_ack_we),
		.wb_dat_i        (wb_dat_s2m),
		.wb_dat_o        (wb_dat_m2s),
		.wb_ack_i        (wb_ack),
		.wb_adr_o        (wb_adr),
		.wb_cyc_o        (wb_cyc),
		.wb_stall_i      (wb_stall),
		.wb_sel_o        (wb_sel),
		.wb_stb_o        (wb_stb),
		.wb_we_o         (wb_we)
	);

	tb_wb_slave #(.BASE(BASE)) i_slave (
		.wb_clk_i   (wb_clk),
		.wb_rst_i   (wb_rst),
		.wb_cyc_i   (wb_cyc),
		.wb_stb_i   (wb_stb),
		.wb_we_i    (wb_we),
		.wb_adr_i   (wb_adr),
		.wb_sel_i   (wb_sel),
		.wb_dat_i   (wb_dat_m2s),
		.wb_stall_o (wb_stall),
		.wb_ack_o   (wb_ack),
		.wb_dat_o   (wb_dat_s2m)
	);

	// ----------------------------
	// Reference model
	// ----------------------------

	function automatic data_t fill_word(input addr_t addr);
		return (addr * 32'h9e37_79b1) ^ 32'h1357_9bdf;
	endfunction

	// First beat of the line in bits 31:0
	function automatic line_t model_line(input addr_t addr);
		logic [5:0] w;
		w = {addr[7:4], 2'b00};
		return {model_mem[w + 3], model_mem[w + 2], model_mem[w + 1], model_mem[w]};
	endfunction

	task automatic apply_write(input addr_t addr, input data_t wdata, input be_t be);
		for (int b = 0; b < 4; b++)
			if (be[b])
				model_mem[addr[7:2]][8*b +: 8] = wdata[8*b +: 8];
	endtask

	task automatic compare_line(input string name, input line_t got, input line_t exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic compare_word(input string name, input data_t got, input data_t exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		checks++;
		assert (cond === 1'b1) else begin
			errors++;
			$display("%s at cycle %0d", what, cyc_cnt);
		end
	endtask

	// ----------------------------
	// Stimulus and checks
	// ----------------------------

	task automatic check_bus_rules();
		check_true(!(wb_stb && !wb_cyc), "wb_stb_o high while wb_cyc_o is low");
		check_true(!(i_dut.tag_if.tag_push && i_dut.tag_if.tag_port == PORT_I && l1d_req_val),
			"instruction request accepted while a data request is valid");
		if (!started)
			check_true(!wb_cyc && !wb_stb && !l1i_req_ack && !l1d_req_ack,
				"bus or acknowledge active before the first request");
	endtask

	task automatic collect_acks();
		logic [5:0] w;
		w = l1d_req_addr[7:2];
		if (l1i_req_ack) begin
			check_true(i_pend, "instruction acknowledge without a pending request");
			if (i_pend) begin
				compare_line("l1i_ack_data_o", l1i_ack_data, model_line(i_addr));
				i_pend = 1'b0;
				i_done++;
			end
		end
		if (l1d_ack_we)
			check_true(l1d_req_ack && d_pend && l1d_req_we, "write acknowledge without a write");
		if (l1d_req_ack) begin
			check_true(d_pend, "data acknowledge without a pending request");
			if (d_pend) begin
				compare_word("l1d_ack_we_o", data_t'(l1d_ack_we), data_t'(l1d_req_we));
				if (l1d_req_we) begin
					apply_write(l1d_req_addr, l1d_req_wdata, l1d_req_be);
				end else if (l1d_req_nc) begin
					compare_word("l1d_ack_nc_o", data_t'(l1d_ack_nc), 32'h1);
					compare_word("l1d_ack_data_o[127:96]", l1d_ack_data[127:96], model_mem[w]);
				end else begin
					compare_word("l1d_ack_nc_o", data_t'(l1d_ack_nc), 32'h0);
					compare_line("l1d_ack_data_o", l1d_ack_data, model_line(l1d_req_addr));
				end
				d_pend = 1'b0;
				d_done++;
			end
		end
	endtask

	task automatic issue_requests();
		logic [1:0] kind;
		addr_t      addr;
		if (!i_pend && i_sent < REQ_PER_PORT && ($random(seed) & 3) != 0) begin
			i_addr = BASE + 32'(($random(seed) & 15) << 4);
			i_pend = 1'b1;
			started = 1'b1;
			i_sent++;
			l1i_req_val  <= 1'b1;
			l1i_req_addr <= i_addr;
		end else if (!i_pend) begin
			l1i_req_val <= 1'b0;
		end
		if (!d_pend && d_sent < REQ_PER_PORT && ($random(seed) & 3) != 0) begin
			// 0 line read, 1 uncached read, 2 and 3 write
			kind = 2'($random(seed));
			addr = BASE + 32'(($random(seed) & 63) << 2);
			if (kind == 2'd0)
				addr[3:0] = 4'h0;
			// A pending line read may already be on the bus
			if (kind[1] && i_pend && addr[31:4] == i_addr[31:4])
				kind = 2'd1;
			d_pend = 1'b1;
			started = 1'b1;
			d_sent++;
			l1d_req_val   <= 1'b1;
			l1d_req_nc    <= (kind == 2'd1);
			l1d_req_we    <= kind[1];
			l1d_req_addr  <= addr;
			l1d_req_wdata <= data_t'($random(seed));
			l1d_req_be    <= be_t'($random(seed));
		end else if (!d_pend) begin
			l1d_req_val <= 1'b0;
		end
	endtask

	initial begin
		seed      = 6585;
		errors    = 0;
		checks    = 0;
		cyc_cnt   = 0;
		started   = 1'b0;
		timed_out = 1'b0;
		i_pend    = 1'b0;
		i_addr    = BASE;
		i_sent    = 0;
		i_done    = 0;
		d_pend    = 1'b0;
		d_sent    = 0;
		d_done    = 0;
		for (int i = 0; i < 64; i++)
			model_mem[i] = fill_word(BASE + 32'(i * 4));
		l1i_req_val   = 1'b0;
		l1i_req_addr  = '0;
		l1d_req_val   = 1'b0;
		l1d_req_nc    = 1'b0;
		l1d_req_we    = 1'b0;
		l1d_req_addr  = '0;
		l1d_req_wdata = '0;
		l1d_req_be    = '0;
	end

	always @(posedge wb_clk) begin
		cyc_cnt <= cyc_cnt + 1;
		if (!wb_rst) begin
			check_bus_rules();
			collect_acks();
			// A few idle cycles after reset
			if (cyc_cnt > RESET_CYCLES + 4)
				issue_requests();
		end
	end

	// End of run
	initial begin
		@(negedge wb_rst);
		while (!(i_done == REQ_PER_PORT && d_done == REQ_PER_PORT) && cyc_cnt < TIMEOUT_CYCLES)
			@(negedge wb_clk);
		timed_out = (cyc_cnt >= TIMEOUT_CYCLES);
		repeat (4) @(posedge wb_clk);
		if (timed_out) begin
			errors++;
			$display("timeout with %0d instruction and %0d data requests done", i_done, d_done);
		end
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

//--- test/tb_wb_slave.sv
// Pipelined Wishbone slave memory
`timescale 1ns/1ps

module tb_wb_slave #(
	parameter logic [31:0] BASE = 32'h0000_4000
) (
	input  logic        wb_clk_i,
	input  logic        wb_rst_i,
	input  logic        wb_cyc_i,
	input  logic        wb_stb_i,
	input  logic        wb_we_i,
	input  logic [31:0] wb_adr_i,
	input  logic [3:0]  wb_sel_i,
	input  logic [31:0] wb_dat_i,
	output logic        wb_stall_o,
	output logic        wb_ack_o,
	output logic [31:0] wb_dat_o
);

	// 64-word window, index taken from the word address
	logic [31:0] mem [64];
	logic [31:0] rd_q [$];
	int          due_q [$];
	int          cyc;
	integer      seed;
	logic [5:0]  widx;

	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return (addr * 32'h9e37_79b1) ^ 32'h1357_9bdf;
	endfunction

	initial begin
		seed       = 6585;
		cyc        = 0;
		wb_stall_o = 1'b0;
		wb_ack_o   = 1'b0;
		wb_dat_o   = '0;
		for (int i = 0; i < 64; i++)
			mem[i] = fill_word(BASE + 32'(i * 4));
	end

	always @(posedge wb_clk_i) begin
		if (wb_rst_i) begin
			rd_q.delete();
			due_q.delete();
			cyc = 0;
			wb_stall_o <= 1'b0;
			wb_ack_o   <= 1'b0;
		end else begin
			// Beat taken: strobe high and not stalled
			if (wb_cyc_i && wb_stb_i && !wb_stall_o) begin
				widx = wb_adr_i[7:2];
				if (wb_we_i) begin
					for (int b = 0; b < 4; b++)
						if (wb_sel_i[b])
							mem[widx][8*b +: 8] = wb_dat_i[8*b +: 8];
					rd_q.push_back('0);
				end else begin
					rd_q.push_back(mem[widx]);
				end
				due_q.push_back(cyc + ($random(seed) & 3));
			end
			// In-order acks, at most one per cycle
			if (due_q.size() > 0 && due_q[0] <= cyc) begin
				wb_ack_o <= 1'b1;
				wb_dat_o <= rd_q.pop_front();
				void'(due_q.pop_front());
			end else begin
				wb_ack_o <= 1'b0;
			end
			wb_stall_o <= (($random(seed) & 3) == 0);
			cyc = cyc + 1;
		end
	end

endmodule

//--- verilog/beat_counter.sv
// Beat down counter
`timescale 1ns/1ps

module beat_counter
	import mau_pkg::*;
(
	input  logic      wb_clk_i,
	input  logic      wb_rst_i,
	input  logic      load_i,
	input  beat_cnt_t load_val_i,
	input  logic      dec_i,
	output beat_cnt_t cnt_o,
	output logic      last_o
);

	// Load wins over decrement
	always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			cnt_o <= '0;
		end else if (load_i) begin
			cnt_o <= load_val_i;
		end else if (dec_i) begin
			cnt_o <= cnt_o - 1'b1;
		end
	end

	assign last_o = (cnt_o == '0);

endmodule

//--- verilog/l1_mau.sv
// L1 memory access unit
`timescale 1ns/1ps

module l1_mau
	import mau_pkg::*;
(
	input  logic  wb_clk_i,
	input  logic  wb_rst_i,

	// Instruction cache
	input  logic  l1i_req_val_i,
	input  addr_t l1i_req_addr_i,
	output logic  l1i_req_ack_o,
	output line_t l1i_ack_data_o,

	// Data cache
	input  logic  l1d_req_val_i,
	input  logic  l1d_req_nc_i,
	input  logic  l1d_req_we_i,
	input  addr_t l1d_req_addr_i,
	input  data_t l1d_req_wdata_i,
	input  be_t   l1d_req_be_i,
	output logic  l1d_req_ack_o,
	output line_t l1d_ack_data_o,
	output logic  l1d_ack_nc_o,
	output logic  l1d_ack_we_o,

	// Wishbone pipelined master
	input  data_t wb_dat_i,
	output data_t wb_dat_o,
	input  logic  wb_ack_i,
	output addr_t wb_adr_o,
	output logic  wb_cyc_o,
	input  logic  wb_stall_i,
	output be_t   wb_sel_o,
	output logic  wb_stb_o,
	output logic  wb_we_o
);

	logic  l1d_rd_ack;
	line_t line;

	mau_hdr_if hdr_if ();
	mau_tag_if tag_if ();

	mau_arbiter i_arbiter (
		.wb_clk_i        (wb_clk_i),
		.wb_rst_i        (wb_rst_i),
		.l1i_req_val_i   (l1i_req_val_i),
		.l1i_req_addr_i  (l1i_req_addr_i),
		.l1i_req_ack_o   (l1i_req_ack_o),
		.l1d_req_val_i   (l1d_req_val_i),
		.l1d_req_nc_i    (l1d_req_nc_i),
		.l1d_req_we_i    (l1d_req_we_i),
		.l1d_req_addr_i  (l1d_req_addr_i),
		.l1d_req_wdata_i (l1d_req_wdata_i),
		.l1d_req_be_i    (l1d_req_be_i),
		.l1d_write_ack_o (l1d_ack_we_o),
		.hdr             (hdr_if.buffer),
		.tag             (tag_if.pusher)
	);

	wb_issue_fsm i_issue (
		.wb_clk_i   (wb_clk_i),
		.wb_rst_i   (wb_rst_i),
		.hdr        (hdr_if.issuer),
		.wb_stall_i (wb_stall_i),
		.wb_stb_o   (wb_stb_o),
		.wb_adr_o   (wb_adr_o),
		.wb_we_o    (wb_we_o),
		.wb_sel_o   (wb_sel_o),
		.wb_dat_o   (wb_dat_o)
	);

	line_assembler i_line (
		.wb_clk_i     (wb_clk_i),
		.wb_rst_i     (wb_rst_i),
		.tag          (tag_if.collector),
		.wb_ack_i     (wb_ack_i),
		.wb_dat_i     (wb_dat_i),
		.wb_cyc_o     (wb_cyc_o),
		.line_o       (line),
		.l1d_rd_ack_o (l1d_rd_ack),
		.l1d_ack_nc_o (l1d_ack_nc_o)
	);

	// Posted write ack or read retire
	assign l1d_req_ack_o  = l1d_ack_we_o | l1d_rd_ack;
	assign l1i_ack_data_o = line;
	assign l1d_ack_data_o = line;

endmodule

//--- verilog/line_assembler.sv
// Acknowledge collector and line builder
`timescale 1ns/1ps

module line_assembler
	import mau_pkg::*;
(
	input  logic         wb_clk_i,
	input  logic         wb_rst_i,
	mau_tag_if.collector tag,
	input  logic         wb_ack_i,
	input  data_t        wb_dat_i,
	output logic         wb_cyc_o,
	output line_t        line_o,
	output logic         l1d_rd_ack_o,
	output logic         l1d_ack_nc_o
);

	logic [$bits(port_e)+1:0] tag_out;
	logic                     tag_empty;
	port_e                    head_port;
	logic                     head_wr;
	logic                     head_nc;
	logic                     head_single;
	ack_state_e               state_r;
	logic                     cnt_last;
	logic                     last_ack;
	logic                     done_r;
	port_e                    done_port_r;
	logic                     done_wr_r;
	logic                     done_nc_r;

	mau_fifo #(
		.WIDTH ($bits(port_e) + 2),
		.DEPTH (TAG_DEPTH)
	) i_tag_buf (
		.wb_clk_i (wb_clk_i),
		.wb_rst_i (wb_rst_i),
		.wr_i     (tag.tag_push),
		.w_data_i ({tag.tag_port, tag.tag_wr, tag.tag_nc}),
		.rd_i     (last_ack),
		.r_data_o (tag_out),
		.empty_o  (tag_empty),
		.full_o   (tag.tag_full)
	);

	assign head_port   = port_e'(tag_out[2]);
	assign head_wr     = tag_out[1];
	assign head_nc     = tag_out[0];
	assign head_single = head_wr | head_nc;

	// ----------------------------
	// Acknowledge tracking
	// ----------------------------

	// Head tag is popped on the last ack, so a back-to-back ack finds its own tag
	assign last_ack = wb_ack_i & ((state_r == ACK_IDLE) ? head_single : cnt_last);

	always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			state_r <= ACK_IDLE;
		end else if (wb_ack_i) begin
			if (state_r == ACK_IDLE && !head_single)
				state_r <= ACK_REC;
			else if (state_r == ACK_REC && cnt_last)
				state_r <= ACK_IDLE;
		end
	end

	// Counts acks still to come after the next one
	beat_counter i_ack_cnt (
		.wb_clk_i   (wb_clk_i),
		.wb_rst_i   (wb_rst_i),
		.load_i     (wb_ack_i & (state_r == ACK_IDLE) & ~head_single),
		.load_val_i (beat_cnt_t'(BEATS_PER_LINE - 2)),
		.dec_i      (wb_ack_i & (state_r == ACK_REC) & ~cnt_last),
		.cnt_o      (),
		.last_o     (cnt_last)
	);

	// Retire pulse one cycle after the last ack
	always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
		if (wb_rst_i)
			done_r <= 1'b0;
		else
			done_r <= last_ack;
	end

	always_ff @(posedge wb_clk_i) begin
		if (last_ack) begin
			done_port_r <= head_port;
			done_wr_r   <= head_wr;
			done_nc_r   <= head_nc;
		end
		// Newest word enters at the top
		if (wb_ack_i)
			line_o <= {wb_dat_i, line_o[$bits(line_t)-1:$bits(data_t)]};
	end

	assign tag.rd_done      = done_r & ~done_wr_r;
	assign tag.rd_done_port = done_port_r;
	assign l1d_rd_ack_o     = tag.rd_done & (done_port_r == PORT_D);
	assign l1d_ack_nc_o     = l1d_rd_ack_o & done_nc_r;
	assign wb_cyc_o         = ~tag_empty;

	a_ack_in_cycle: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		wb_ack_i |-> !tag_empty);

endmodule

//--- verilog/mau_arbiter.sv
// Port arbiter and request buffers
`timescale 1ns/1ps

module mau_arbiter
	import mau_pkg::*;
(
	input  logic      wb_clk_i,
	input  logic      wb_rst_i,
	input  logic      l1i_req_val_i,
	input  addr_t     l1i_req_addr_i,
	output logic      l1i_req_ack_o,
	input  logic      l1d_req_val_i,
	input  logic      l1d_req_nc_i,
	input  logic      l1d_req_we_i,
	input  addr_t     l1d_req_addr_i,
	input  data_t     l1d_req_wdata_i,
	input  be_t       l1d_req_be_i,
	output logic      l1d_write_ack_o,
	mau_hdr_if.buffer hdr,
	mau_tag_if.pusher tag
);

	logic                                d_acc;
	logic                                i_acc;
	logic                                req_wr;
	logic                                req_nc;
	be_t                                 req_be;
	addr_t                               req_addr;
	logic [$bits(addr_t)+$bits(be_t)+1:0] hdr_out;
	logic                                hdr_empty;
	logic                                hdr_full;
	logic                                wdat_full;
	logic                                d_rd_out_r;
	logic                                i_rd_out_r;

	// ----------------------------
	// Acceptance
	// ----------------------------

	assign d_acc = l1d_req_val_i & ~hdr_full & ~tag.tag_full & ~d_rd_out_r &
		(~l1d_req_we_i | ~wdat_full);
	// Instruction side only gets the slot when data side is quiet
	assign i_acc = l1i_req_val_i & ~l1d_req_val_i & ~hdr_full & ~tag.tag_full &
		~i_rd_out_r;

	assign req_wr   = d_acc & l1d_req_we_i;
	assign req_nc   = d_acc & l1d_req_nc_i;
	assign req_be   = req_wr ? l1d_req_be_i : '1;
	assign req_addr = d_acc ? l1d_req_addr_i : l1i_req_addr_i;

	// At most one read in flight per port
	always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			d_rd_out_r <= 1'b0;
			i_rd_out_r <= 1'b0;
		end else begin
			if (tag.rd_done && tag.rd_done_port == PORT_D)
				d_rd_out_r <= 1'b0;
			else if (d_acc && !l1d_req_we_i)
				d_rd_out_r <= 1'b1;
			if (tag.rd_done && tag.rd_done_port == PORT_I)
				i_rd_out_r <= 1'b0;
			else if (i_acc)
				i_rd_out_r <= 1'b1;
		end
	end

	// ----------------------------
	// Buffers
	// ----------------------------

	mau_fifo #(
		.WIDTH ($bits(addr_t) + $bits(be_t) + 2),
		.DEPTH (HDR_DEPTH)
	) i_hdr_buf (
		.wb_clk_i (wb_clk_i),
		.wb_rst_i (wb_rst_i),
		.wr_i     (d_acc | i_acc),
		.w_data_i ({req_wr, req_nc, req_be, req_addr}),
		.rd_i     (hdr.hdr_done),
		.r_data_o (hdr_out),
		.empty_o  (hdr_empty),
		.full_o   (hdr_full)
	);

	mau_fifo #(
		.WIDTH ($bits(data_t)),
		.DEPTH (WDATA_DEPTH)
	) i_wdat_buf (
		.wb_clk_i (wb_clk_i),
		.wb_rst_i (wb_rst_i),
		.wr_i     (req_wr),
		.w_data_i (l1d_req_wdata_i),
		.rd_i     (hdr.hdr_done & hdr.hdr_wr),
		.r_data_o (hdr.hdr_wdata),
		.empty_o  (),
		.full_o   (wdat_full)
	);

	assign hdr.hdr_valid = ~hdr_empty;
	assign {hdr.hdr_wr, hdr.hdr_nc, hdr.hdr_be, hdr.hdr_addr} = hdr_out;

	// Tag goes out together with the header
	assign tag.tag_push = d_acc | i_acc;
	assign tag.tag_port = d_acc ? PORT_D : PORT_I;
	assign tag.tag_wr   = req_wr;
	assign tag.tag_nc   = req_nc;

	// Writes are posted
	assign l1d_write_ack_o = req_wr;
	assign l1i_req_ack_o   = tag.rd_done & (tag.rd_done_port == PORT_I);

endmodule

//--- verilog/mau_fifo.sv
// Synchronous FIFO
`timescale 1ns/1ps

module mau_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 4
) (
	input  logic             wb_clk_i,
	input  logic             wb_rst_i,
	input  logic             wr_i,
	input  logic [WIDTH-1:0] w_data_i,
	input  logic             rd_i,
	output logic [WIDTH-1:0] r_data_o,
	output logic             empty_o,
	output logic             full_o
);

	// Pointers wrap on their own, depth is a power of two
	logic [WIDTH-1:0]         mem [DEPTH];
	logic [$clog2(DEPTH)-1:0] wr_ptr;
	logic [$clog2(DEPTH)-1:0] rd_ptr;
	logic [$clog2(DEPTH):0]   count;

	always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_i)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_i)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_i, rd_i})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (wr_i)
			mem[wr_ptr] <= w_data_i;
	end

	assign r_data_o = mem[rd_ptr];
	assign empty_o  = (count == '0);
	assign full_o   = (count == ($clog2(DEPTH) + 1)'(DEPTH));

	a_no_overflow: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		!(wr_i && full_o));
	a_no_underflow: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		!(rd_i && empty_o));

endmodule

//--- verilog/mau_hdr_if.sv
// Request head interface
`timescale 1ns/1ps

interface mau_hdr_if
	import mau_pkg::*;
();

	// Head of the header and write-data buffers
	logic  hdr_valid;
	logic  hdr_wr;
	logic  hdr_nc;
	be_t   hdr_be;
	addr_t hdr_addr;
	data_t hdr_wdata;
	// Final beat of the head taken by the bus
	logic  hdr_done;

	modport buffer (
		output hdr_valid, hdr_wr, hdr_nc, hdr_be, hdr_addr, hdr_wdata,
		input  hdr_done
	);

	modport issuer (
		input  hdr_valid, hdr_wr, hdr_nc, hdr_be, hdr_addr, hdr_wdata,
		output hdr_done
	);

endinterface

//--- verilog/mau_pkg.sv
// Memory access unit definitions
package mau_pkg;

	// ----------------------------
	// Widths
	// ----------------------------

	// Byte address, core side and bus side
	typedef logic [31:0]  addr_t;
	// One bus word
	typedef logic [31:0]  data_t;
	typedef logic [3:0]   be_t;
	// One cache line
	typedef logic [127:0] line_t;

	localparam int BEATS_PER_LINE = $bits(line_t) / $bits(data_t);

	// Beats remaining after the current one
	typedef logic [$clog2(BEATS_PER_LINE)-1:0] beat_cnt_t;

	// ----------------------------
	// Buffer depths
	// ----------------------------

	localparam int HDR_DEPTH   = 4;
	localparam int WDATA_DEPTH = 2;
	localparam int TAG_DEPTH   = 4;

	// ----------------------------
	// Encodings
	// ----------------------------

	typedef enum logic {
		PORT_I = 1'b0,
		PORT_D = 1'b1
	} port_e;

	typedef enum logic {
		ISS_IDLE = 1'b0,
		ISS_REQ  = 1'b1
	} issue_state_e;

	typedef enum logic {
		ACK_IDLE = 1'b0,
		ACK_REC  = 1'b1
	} ack_state_e;

endpackage

//--- verilog/mau_tag_if.sv
// Acknowledge tag interface
`timescale 1ns/1ps

interface mau_tag_if
	import mau_pkg::*;
();

	// Pushed in the accept cycle
	logic  tag_push;
	port_e tag_port;
	logic  tag_wr;
	logic  tag_nc;

	// Back from the collector
	logic  tag_full;
	logic  rd_done;
	port_e rd_done_port;

	modport pusher (
		output tag_push, tag_port, tag_wr, tag_nc,
		input  tag_full, rd_done, rd_done_port
	);

	modport collector (
		input  tag_push, tag_port, tag_wr, tag_nc,
		output tag_full, rd_done, rd_done_port
	);

endinterface

//--- verilog/wb_issue_fsm.sv
// Wishbone request issuer
`timescale 1ns/1ps

module wb_issue_fsm
	import mau_pkg::*;
(
	input  logic      wb_clk_i,
	input  logic      wb_rst_i,
	mau_hdr_if.issuer hdr,
	input  logic      wb_stall_i,
	output logic      wb_stb_o,
	output addr_t     wb_adr_o,
	output logic      wb_we_o,
	output be_t       wb_sel_o,
	output data_t     wb_dat_o
);

	issue_state_e state_r;
	logic         start;
	logic         taken;
	logic         last;
	beat_cnt_t    beat_cnt;

	assign start = (state_r == ISS_IDLE) & hdr.hdr_valid;
	// Beat accepted by the slave
	assign taken = (state_r == ISS_REQ) & ~wb_stall_i;
	assign hdr.hdr_done = taken & last;

	always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			state_r <= ISS_IDLE;
		end else begin
			case (state_r)
				ISS_IDLE: begin
					if (hdr.hdr_valid)
						state_r <= ISS_REQ;
				end
				ISS_REQ: begin
					if (taken && last)
						state_r <= ISS_IDLE;
				end
				default: state_r <= ISS_IDLE;
			endcase
		end
	end

	beat_counter i_beat_cnt (
		.wb_clk_i   (wb_clk_i),
		.wb_rst_i   (wb_rst_i),
		.load_i     (start),
		.load_val_i ((hdr.hdr_wr | hdr.hdr_nc) ? '0 : beat_cnt_t'(BEATS_PER_LINE - 1)),
		.dec_i      (taken & ~last),
		.cnt_o      (beat_cnt),
		.last_o     (last)
	);

	// Word address walks through the line
	always_ff @(posedge wb_clk_i) begin
		if (start)
			wb_adr_o <= hdr.hdr_addr;
		else if (taken)
			wb_adr_o <= wb_adr_o + addr_t'($bits(data_t) / 8);
	end

	assign wb_stb_o = (state_r == ISS_REQ);
	assign wb_we_o  = hdr.hdr_wr;
	assign wb_sel_o = hdr.hdr_be;
	assign wb_dat_o = hdr.hdr_wdata;

	a_stall_hold: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		wb_stb_o && wb_stall_i |=> $stable(wb_adr_o));
	// Line reads start on a line boundary
	a_line_offset: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		wb_stb_o && !hdr.hdr_wr && !hdr.hdr_nc |-> wb_adr_o[3:2] == ~beat_cnt);

endmodule
